//--- compile.f
+incdir+logic
logic/i2c_bus_pkg.sv
logic/i2c_txn_pkg.sv
logic/i2c_bit_if.sv
logic/sync_fifo.sv
logic/i2c_bit_engine.sv
logic/i2c_txn_controller.sv
logic/i2c_master_top.sv
sim/i2c_target_model.sv
sim/tb_i2c_master.sv

//--- logic/i2c_bit_engine.sv
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_bit_engine (
    input  logic                  clock,
    input  logic                  reset_n,
    input  i2c_bus_pkg::divider_t divider,
    i2c_bit_if.engine             bit_port,
    input  logic                  scl_in,
    input  logic                  sda_in,
    output logic                  scl_out,
    output logic                  sda_out
);
    import i2c_bus_pkg::*;

    localparam stretch_count_t stretch_limit = stretch_count_t'(`I2C_STRETCH_MAX_TICKS);

    logic           busy;
    logic           tick;
    logic           stalled;
    phase_t         phase;
    phase_t         next_phase;
    divider_t       div_count;
    stretch_count_t stretch_count;

    // {scl, sda} for one quarter of a symbol
    function automatic logic [1:0] levels(bit_op_t op, phase_t ph, logic tx);
        logic [1:0] lv;
        case (op)
            op_start:    lv = (ph == 2'd0) ? 2'b11 : (ph == 2'd1) ? 2'b10 : 2'b00;
            op_restart:  lv = (ph == 2'd0) ? 2'b01 : (ph == 2'd3) ? 2'b00 : {1'b1, ph == 2'd1};
            op_stop:     lv = (ph == 2'd0) ? 2'b00 : {1'b1, ph[1]};
            op_read_bit: lv = {ph[1] ^ ph[0], 1'b1};
            default:     lv = {ph[1] ^ ph[0], tx};
        endcase
        return lv;
    endfunction

    //////////////////////////////
    // quarter tick divider

    assign tick = busy && (div_count == '0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            div_count <= '0;
        end else if (bit_port.go || tick) begin
            div_count <= divider - 16'd1;
        end else if (busy) begin
            div_count <= div_count - 16'd1;
        end
    end

    //////////////////////////////
    // phase sequencing

    // released SCL still low means the target is stretching
    assign stalled    = scl_out && !scl_in;
    assign next_phase = phase + 2'd1;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy             <= 1'b0;
            phase            <= '0;
            stretch_count    <= '0;
            scl_out          <= 1'b1;
            sda_out          <= 1'b1;
            bit_port.done    <= 1'b0;
            bit_port.timeout <= 1'b0;
            bit_port.rx_bit  <= 1'b1;
        end else begin
            bit_port.done    <= 1'b0;
            bit_port.timeout <= 1'b0;
            if (bit_port.go) begin
                busy               <= 1'b1;
                phase              <= '0;
                stretch_count      <= '0;
                {scl_out, sda_out} <= levels(bit_port.op, 2'd0, bit_port.tx_bit);
            end else if (tick && stalled) begin
                if (stretch_count == stretch_limit) begin
                    // abandon the symbol, float both lines
                    busy             <= 1'b0;
                    scl_out          <= 1'b1;
                    sda_out          <= 1'b1;
                    bit_port.done    <= 1'b1;
                    bit_port.timeout <= 1'b1;
                end else begin
                    stretch_count <= stretch_count + 1'b1;
                end
            end else if (tick) begin
                stretch_count <= '0;
                // sample late in the high half of SCL
                if (phase == 2'd2) begin
                    bit_port.rx_bit <= sda_in;
                end
                if (phase == 2'd3) begin
                    busy          <= 1'b0;
                    bit_port.done <= 1'b1;
                end else begin
                    phase              <= next_phase;
                    {scl_out, sda_out} <= levels(bit_port.op, next_phase, bit_port.tx_bit);
                end
            end
        end
    end
endmodule

//--- logic/i2c_bit_if.sv
`timescale 1ns/1ps

interface i2c_bit_if;
    import i2c_bus_pkg::*;

    // request side
    logic    go;
    bit_op_t op;
    logic    tx_bit;

    // completion side, one cycle pulses
    logic    done;
    logic    rx_bit;
    logic    timeout;

    modport ctrl (
        output go, op, tx_bit,
        input  done, rx_bit, timeout
    );

    modport engine (
        input  go, op, tx_bit,
        output done, rx_bit, timeout
    );
endinterface

//--- logic/i2c_bus_pkg.sv
`include "i2c_config.svh"

package i2c_bus_pkg;

    // clock cycles per quarter bit period
    typedef logic [15:0] divider_t;
    typedef logic [$clog2(`I2C_STRETCH_MAX_TICKS + 1) - 1:0] stretch_count_t;
    typedef logic [1:0] phase_t;

    // one symbol on the bus, four quarter phases each
    typedef enum logic [2:0] {
        op_start, op_restart, op_write_bit, op_read_bit, op_stop
    } bit_op_t;

endpackage

//--- logic/i2c_config.svh
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// fifo depths, entries
`define I2C_CMD_FIFO_DEPTH 2
`define I2C_DATA_FIFO_DEPTH 2

// divider ticks a target may hold SCL low
`define I2C_STRETCH_MAX_TICKS 31

// host side word widths
`define I2C_BYTE_WIDTH 8
`define I2C_CMD_WIDTH 24

`endif

//--- logic/i2c_master_top.sv
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_master_top (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   s_axis_cmd_valid,
    output logic                   s_axis_cmd_ready,
    input  i2c_txn_pkg::cmd_word_t s_axis_cmd_data,
    input  logic                   s_axis_data_valid,
    output logic                   s_axis_data_ready,
    input  i2c_txn_pkg::byte_t     s_axis_data,
    output logic                   m_axis_data_valid,
    input  logic                   m_axis_data_ready,
    output i2c_txn_pkg::byte_t     m_axis_data,
    input  i2c_bus_pkg::divider_t  divider,
    input  logic                   sda_in,
    output logic                   sda_out,
    input  logic                   scl_in,
    output logic                   scl_out
);
    import i2c_txn_pkg::*;

    logic      cmd_valid;
    logic      cmd_ready;
    cmd_word_t cmd_data;
    logic      wr_valid;
    logic      wr_ready;
    byte_t     wr_data;
    logic      rd_valid;
    logic      rd_ready;
    byte_t     rd_data;

    i2c_bit_if bit_bus ();

    //////////////////////////////
    // host side queues

    sync_fifo #(.width(`I2C_CMD_WIDTH), .depth(`I2C_CMD_FIFO_DEPTH)) cmd_fifo (
        .clock(clock), .reset_n(reset_n),
        .in_valid(s_axis_cmd_valid), .in_ready(s_axis_cmd_ready), .in_data(s_axis_cmd_data),
        .out_valid(cmd_valid), .out_ready(cmd_ready), .out_data(cmd_data)
    );

    sync_fifo #(.width(`I2C_BYTE_WIDTH), .depth(`I2C_DATA_FIFO_DEPTH)) wr_fifo (
        .clock(clock), .reset_n(reset_n),
        .in_valid(s_axis_data_valid), .in_ready(s_axis_data_ready), .in_data(s_axis_data),
        .out_valid(wr_valid), .out_ready(wr_ready), .out_data(wr_data)
    );

    // read bytes back to the host
    sync_fifo #(.width(`I2C_BYTE_WIDTH), .depth(`I2C_DATA_FIFO_DEPTH)) rd_fifo (
        .clock(clock), .reset_n(reset_n),
        .in_valid(rd_valid), .in_ready(rd_ready), .in_data(rd_data),
        .out_valid(m_axis_data_valid), .out_ready(m_axis_data_ready), .out_data(m_axis_data)
    );

    //////////////////////////////
    // controller and bus engine

    i2c_txn_controller i2c_txn_controller_inst (
        .clock(clock), .reset_n(reset_n),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_data(cmd_data),
        .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_data(wr_data),
        .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_data(rd_data),
        .bit_port(bit_bus)
    );

    i2c_bit_engine i2c_bit_engine_inst (
        .clock(clock), .reset_n(reset_n),
        .divider(divider),
        .bit_port(bit_bus),
        .scl_in(scl_in), .sda_in(sda_in),
        .scl_out(scl_out), .sda_out(sda_out)
    );
endmodule

//--- logic/i2c_txn_controller.sv
`timescale 1ns/1ps

module i2c_txn_controller (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  i2c_txn_pkg::cmd_word_t cmd_data,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  i2c_txn_pkg::byte_t     wr_data,
    output logic                   rd_valid,
    input  logic                   rd_ready,
    output i2c_txn_pkg::byte_t     rd_data,
    i2c_bit_if.ctrl                bit_port
);
    import i2c_bus_pkg::*;
    import i2c_txn_pkg::*;

    txn_state_t  state;
    txn_state_t  after_ack;
    cmd_word_t   cmd;
    byte_t       shift;
    bit_index_t  bit_idx;
    byte_count_t count;
    logic        pending;
    logic        ack_phase;
    logic        flush;
    logic        issue;
    bit_op_t     issue_op;
    logic        issue_tx;

    // count holds the bytes not yet moved through a data FIFO
    // leftovers of an aborted write are dropped while idle
    assign flush     = (state == idle) && !pending && !cmd.read && (count != '0);
    assign cmd_ready = (state == idle) && !pending && !flush;
    assign wr_ready  = flush || ((state == write_data) && !pending && !ack_phase
                                 && (bit_idx == '0));
    assign rd_valid  = (state == ack_out) && !pending;
    assign rd_data   = shift;

    always_comb begin
        case (state)
            addr_w:   after_ack = reg_addr;
            reg_addr: after_ack = (count == '0) ? stop : (cmd.read ? restart : write_data);
            addr_r:   after_ack = read_data;
            default:  after_ack = (count == '0) ? stop : write_data;
        endcase
        // target NACK ends the transfer
        if (bit_port.rx_bit) begin
            after_ack = stop;
        end
    end

    //////////////////////////////
    // next symbol to request

    always_comb begin
        issue    = 1'b0;
        issue_op = op_write_bit;
        issue_tx = 1'b1;
        if (!pending) begin
            case (state)
                idle: begin
                    issue    = cmd_valid && cmd_ready;
                    issue_op = op_start;
                end
                restart: begin
                    issue    = 1'b1;
                    issue_op = op_restart;
                end
                stop: begin
                    issue    = 1'b1;
                    issue_op = op_stop;
                end
                read_data: begin
                    issue    = 1'b1;
                    issue_op = op_read_bit;
                end
                // byte is pushed as its ACK/NACK goes out
                ack_out: begin
                    issue    = rd_ready;
                    issue_tx = (count == 8'd1);
                end
                write_data: begin
                    issue    = ack_phase || wr_valid;
                    issue_op = ack_phase ? op_read_bit : op_write_bit;
                    issue_tx = ack_phase || wr_data[bit_idx];
                end
                default: begin
                    issue    = 1'b1;
                    issue_op = ack_phase ? op_read_bit : op_write_bit;
                    issue_tx = ack_phase || shift[bit_idx];
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            cmd   <= '0;
            count <= '0;
        end else if (cmd_valid && cmd_ready) begin
            cmd   <= cmd_data;
            count <= cmd_data.count;
        end else if ((wr_valid && wr_ready) || (rd_valid && rd_ready)) begin
            count <= count - 8'd1;
        end
    end

    //////////////////////////////
    // transaction sequencing

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state           <= idle;
            shift           <= '0;
            bit_idx         <= '0;
            pending         <= 1'b0;
            ack_phase       <= 1'b0;
            bit_port.go     <= 1'b0;
            bit_port.op     <= op_stop;
            bit_port.tx_bit <= 1'b1;
        end else begin
            bit_port.go <= issue;
            if (issue) begin
                pending         <= 1'b1;
                bit_port.op     <= issue_op;
                bit_port.tx_bit <= issue_tx;
            end else if (pending && bit_port.done) begin
                pending <= 1'b0;
                if (bit_port.timeout) begin
                    state     <= idle;
                    ack_phase <= 1'b0;
                end else begin
                    case (state)
                        idle: begin
                            state   <= addr_w;
                            shift   <= {cmd.dev_addr, 1'b0};
                            bit_idx <= 3'd7;
                        end
                        restart: begin
                            state   <= addr_r;
                            shift   <= {cmd.dev_addr, 1'b1};
                            bit_idx <= 3'd7;
                        end
                        addr_w, reg_addr, addr_r, write_data: begin
                            // index wraps to 7 for the next byte
                            if (!ack_phase) begin
                                ack_phase <= (bit_idx == '0);
                                bit_idx   <= bit_idx - 3'd1;
                            end else begin
                                ack_phase <= 1'b0;
                                state     <= after_ack;
                                shift     <= cmd.reg_addr;
                            end
                        end
                        read_data: begin
                            shift[bit_idx] <= bit_port.rx_bit;
                            bit_idx        <= bit_idx - 3'd1;
                            if (bit_idx == '0) begin
                                state <= ack_out;
                            end
                        end
                        ack_out: state <= (count == '0) ? stop : read_data;
                        default: state <= idle;
                    endcase
                end
            end
        end
    end
endmodule

//--- logic/i2c_txn_pkg.sv
`include "i2c_config.svh"

package i2c_txn_pkg;

    typedef logic [`I2C_BYTE_WIDTH-1:0] byte_t;
    typedef logic [6:0] dev_addr_t;
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] byte_count_t;
    typedef logic [2:0] bit_index_t;

    // host command word, msb first
    typedef struct packed {
        dev_addr_t   dev_addr;
        logic        read;
        byte_count_t count;
        reg_addr_t   reg_addr;
    } cmd_word_t;

    typedef enum logic [3:0] {
        idle, addr_w, reg_addr, restart, addr_r, write_data, read_data, ack_out, stop
    } txn_state_t;

endpackage

//--- logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 2
) (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [width-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [width-1:0] out_data
);
    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    logic [width-1:0]     mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] fill;
    logic                 push;
    logic                 pop;

    assign in_ready  = (fill != cnt_width'(depth));
    assign out_valid = (fill != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // pointer wrap for any depth
    function automatic logic [ptr_width-1:0] bump(logic [ptr_width-1:0] ptr);
        return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
        end
    end
endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the I2C master testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_i2c_master -f compile.f \
        --Mdir build -o sim_tb; then
    echo "verilator compile failed"
    exit 1
fi

./build/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- sim/i2c_golden.txt
# op and hex fields: D divider | S stretch_ticks | W addr reg count bytes
# R addr reg count expected_bytes (stretch applies to the next transaction only)
D 4
W 50 10 3 a5 3c 7e
R 50 10 3 a5 3c 7e
W 23 20 2 11 22
R 23 10 2 a5 3c
W 50 40 2 c1 d2
S 14
R 50 40 2 c1 d2
S 3c
W 50 60 2 99 88
R 50 10 1 a5
D 6
W 50 10 3 a5 3c 7e
R 50 10 3 a5 3c 7e

//--- sim/i2c_target_model.sv
`timescale 1ns/1ps

module i2c_target_model #(
    parameter logic [6:0] address = 7'h50
) (
    input  logic       scl,
    input  logic       sda,
    input  int         stretch_ns,
    output logic       scl_pull,
    output logic       sda_pull,
    output logic [7:0] log_byte,
    output logic       log_toggle
);
    logic [7:0] mem [256];
    logic [7:0] shreg;
    logic [7:0] ptr;
    int         nbits;
    logic       active;
    logic       first;
    logic       addressed;
    logic       rw;
    logic       reg_phase;
    logic       reading;
    logic       start_read;
    logic       stretch_pending;

    initial begin
        scl_pull   = 1'b0;
        sda_pull   = 1'b0;
        log_byte   = '0;
        log_toggle = 1'b0;
        active     = 1'b0;
        reading    = 1'b0;
        start_read = 1'b0;
        ptr        = '0;
        nbits      = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'hc3;
        end
    end

    //////////////////////////////
    // START and STOP detection

    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active          = 1'b1;
            first           = 1'b1;
            addressed       = 1'b0;
            reading         = 1'b0;
            start_read      = 1'b0;
            nbits           = 0;
            sda_pull        = 1'b0;
            stretch_pending = (stretch_ns > 0);
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active  = 1'b0;
            reading = 1'b0;
        end
    end

    //////////////////////////////
    // bit level behavior

    always @(posedge scl) begin
        if (active) begin
            if (nbits < 8 && !reading) begin
                shreg = {shreg[6:0], sda};
            end
            // master NACK ends the read
            if (nbits == 8 && reading && sda) begin
                reading = 1'b0;
            end
            nbits = nbits + 1;
        end
    end

    always @(negedge scl) begin
        if (active) begin
            if (nbits == 0 && stretch_pending) begin
                stretch_pending = 1'b0;
                scl_pull        = 1'b1;
                #(stretch_ns);
                scl_pull        = 1'b0;
            end else if (nbits == 8) begin
                if (reading) begin
                    sda_pull = 1'b0;
                end else if (first) begin
                    first      = 1'b0;
                    addressed  = (shreg[7:1] == address);
                    rw         = shreg[0];
                    reg_phase  = !shreg[0];
                    start_read = addressed && shreg[0];
                    sda_pull   = addressed;
                end else if (addressed && !rw) begin
                    log_byte   = shreg;
                    log_toggle = !log_toggle;
                    if (reg_phase) begin
                        ptr       = shreg;
                        reg_phase = 1'b0;
                    end else begin
                        mem[ptr] = shreg;
                        ptr      = ptr + 8'd1;
                    end
                    sda_pull = 1'b1;
                end
            end else if (nbits == 9) begin
                sda_pull = 1'b0;
                nbits    = 0;
                if (reading || start_read) begin
                    start_read = 1'b0;
                    reading    = 1'b1;
                    shreg      = mem[ptr];
                    ptr        = ptr + 8'd1;
                    sda_pull   = !shreg[7];
                end
            end else if (reading && nbits >= 1 && nbits <= 7) begin
                sda_pull = !shreg[7 - nbits];
            end
        end
    end
endmodule

//--- sim/tb_i2c_master.sv
`timescale 1ns/1ps
`include "i2c_config.svh"

module tb_i2c_master;
    import i2c_bus_pkg::*;
    import i2c_txn_pkg::*;

    localparam dev_addr_t target_addr = 7'h50;

    logic      clock = 1'b0;
    logic      reset_n = 1'b0;
    logic      s_axis_cmd_valid;
    logic      s_axis_cmd_ready;
    cmd_word_t s_axis_cmd_data;
    logic      s_axis_data_valid;
    logic      s_axis_data_ready;
    byte_t     s_axis_data;
    logic      m_axis_data_valid;
    logic      m_axis_data_ready;
    byte_t     m_axis_data;
    divider_t  divider;
    logic      scl_out;
    logic      sda_out;
    logic      scl_pull;
    logic      sda_pull;
    logic      scl_bus;
    logic      sda_bus;
    int        stretch_ns;
    byte_t     log_byte;
    logic      log_toggle;
    int        cur_div;
    byte_t     read_q[$];
    byte_t     log_q[$];

    // golden operations parsed up front
    string     op_kind[$];
    int        op_a[$];
    int        op_reg[$];
    int        op_cnt[$];
    int        op_first[$];
    byte_t     data_q[$];

    always #5 clock = ~clock;

    // open-drain wired AND
    assign scl_bus = scl_out & ~scl_pull;
    assign sda_bus = sda_out & ~sda_pull;

    i2c_master_top i2c_master_top_inst (
        .clock(clock), .reset_n(reset_n),
        .s_axis_cmd_valid(s_axis_cmd_valid), .s_axis_cmd_ready(s_axis_cmd_ready),
        .s_axis_cmd_data(s_axis_cmd_data),
        .s_axis_data_valid(s_axis_data_valid), .s_axis_data_ready(s_axis_data_ready),
        .s_axis_data(s_axis_data),
        .m_axis_data_valid(m_axis_data_valid), .m_axis_data_ready(m_axis_data_ready),
        .m_axis_data(m_axis_data),
        .divider(divider),
        .sda_in(sda_bus), .sda_out(sda_out), .scl_in(scl_bus), .scl_out(scl_out)
    );

    i2c_target_model #(.address(target_addr)) i2c_target_model_inst (
        .scl(scl_bus), .sda(sda_bus), .stretch_ns(stretch_ns),
        .scl_pull(scl_pull), .sda_pull(sda_pull),
        .log_byte(log_byte), .log_toggle(log_toggle)
    );

    //////////////////////////////
    // read stream sink with random back-pressure

    always @(posedge clock) begin
        m_axis_data_ready <= ($urandom % 2) == 0;
    end

    always @(negedge clock) begin
        if (m_axis_data_valid && m_axis_data_ready) begin
            read_q.push_back(m_axis_data);
        end
    end

    always @(log_toggle) begin
        log_q.push_back(log_byte);
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_command(input cmd_word_t c);
        @(posedge clock);
        s_axis_cmd_valid <= 1'b1;
        s_axis_cmd_data  <= c;
        do @(negedge clock); while (!s_axis_cmd_ready);
        @(posedge clock);
        s_axis_cmd_valid <= 1'b0;
    endtask

    task automatic send_byte(input byte_t b);
        @(posedge clock);
        s_axis_data_valid <= 1'b1;
        s_axis_data       <= b;
        do @(negedge clock); while (!s_axis_data_ready);
        @(posedge clock);
        s_axis_data_valid <= 1'b0;
    endtask

    // both lines high for eight quarter ticks means the transfer is over
    task automatic wait_bus_idle();
        int quiet;
        quiet = 0;
        while (quiet < 8 * cur_div) begin
            @(negedge clock);
            if (scl_out && sda_out && scl_bus && sda_bus) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    initial begin
        int        fd;
        int        n;
        int        v;
        int        a;
        int        r;
        int        c;
        int        stretch;
        int        max_div;
        int        ticks;
        bit        ok;
        real       limit_ns;
        string     tok;
        string     line;
        cmd_word_t cmd;

        v = $urandom(32'hab26989f);
        s_axis_cmd_valid  = 1'b0;
        s_axis_cmd_data   = '0;
        s_axis_data_valid = 1'b0;
        s_axis_data       = '0;
        m_axis_data_ready = 1'b0;
        divider           = 16'd4;
        cur_div           = 4;
        stretch_ns        = 0;

        fd = $fopen("sim/i2c_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file sim/i2c_golden.txt");
            $display("STATUS: FAIL");
            $fatal(1, "missing golden file");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %s", tok);
            if (n != 1) begin
                break;
            end
            if (tok == "#") begin
                n = $fgets(line, fd);
            end else begin
                a = 0;
                r = 0;
                c = 0;
                if (tok == "W" || tok == "R") begin
                    n = $fscanf(fd, " %h %h %h", a, r, c);
                end else begin
                    n = $fscanf(fd, " %h", a);
                end
                op_kind.push_back(tok);
                op_a.push_back(a);
                op_reg.push_back(r);
                op_cnt.push_back(c);
                op_first.push_back(data_q.size());
                for (int i = 0; i < c; i++) begin
                    n = $fscanf(fd, " %h", v);
                    data_q.push_back(byte_t'(v));
                end
            end
        end
        $fclose(fd);

        // twice the bus time of all symbols, idle gaps and stretches
        ticks   = 0;
        max_div = 4;
        stretch = 0;
        foreach (op_kind[i]) begin
            if (op_kind[i] == "D" && op_a[i] > max_div) begin
                max_div = op_a[i];
            end else if (op_kind[i] == "S") begin
                stretch = op_a[i];
            end else if (op_kind[i] == "W" || op_kind[i] == "R") begin
                ticks   += 4 * (9 * (3 + op_cnt[i]) + 4) + 16 + 2 * stretch;
                stretch = 0;
            end
        end
        limit_ns = 2.0 * ticks * max_div * 10.0 + 10000.0;
        fork
            begin
                #(limit_ns);
                $display("watchdog expired: the golden transactions did not finish in time");
                $display("STATUS: FAIL");
                $fatal(1, "watchdog timeout");
            end
        join_none

        repeat (8) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_value(scl_out, 1'b1, "scl_out after reset");
        check_value(sda_out, 1'b1, "sda_out after reset");
        check_value(s_axis_cmd_ready, 1'b1, "s_axis_cmd_ready after reset");
        check_value(s_axis_data_ready, 1'b1, "s_axis_data_ready after reset");
        check_value(m_axis_data_valid, 1'b0, "m_axis_data_valid after reset");

        stretch = 0;
        foreach (op_kind[i]) begin
            if (op_kind[i] == "D") begin
                @(posedge clock);
                divider <= divider_t'(op_a[i]);
                cur_div = op_a[i];
            end else if (op_kind[i] == "S") begin
                stretch = op_a[i];
            end else begin
                // stretch beyond the limit or an absent target moves nothing
                ok = (op_a[i] == target_addr) && (stretch < `I2C_STRETCH_MAX_TICKS);
                read_q.delete();
                log_q.delete();
                @(posedge clock);
                stretch_ns <= stretch * cur_div * 10;
                cmd.dev_addr = dev_addr_t'(op_a[i]);
                cmd.read     = (op_kind[i] == "R");
                cmd.count    = byte_count_t'(op_cnt[i]);
                cmd.reg_addr = reg_addr_t'(op_reg[i]);
                send_command(cmd);
                if (!cmd.read) begin
                    for (int k = 0; k < op_cnt[i]; k++) begin
                        send_byte(data_q[op_first[i] + k]);
                    end
                end
                wait_bus_idle();
                if (!ok) begin
                    check_value(log_q.size(), 0, "target write log length");
                    check_value(read_q.size(), 0, "read byte count");
                end else if (cmd.read) begin
                    check_value(log_q.size(), 1, "target write log length");
                    check_value(log_q[0], op_reg[i], "logged register address");
                    check_value(read_q.size(), op_cnt[i], "read byte count");
                    foreach (read_q[k]) begin
                        check_value(read_q[k], data_q[op_first[i] + k], "read byte");
                    end
                end else begin
                    check_value(log_q.size(), op_cnt[i] + 1, "target write log length");
                    check_value(log_q[0], op_reg[i], "logged register address");
                    for (int k = 0; k < op_cnt[i]; k++) begin
                        check_value(log_q[k + 1], data_q[op_first[i] + k], "written byte");
                    end
                    check_value(read_q.size(), 0, "read byte count");
                end
                stretch = 0;
                @(posedge clock);
                stretch_ns <= 0;
            end
        end

        $display("STATUS: PASS");
        $finish;
    end
endmodule
